//--- src/rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    localparam int IQ_DEPTH = 4;                  // power of two, pointers wrap
    localparam int IQ_PTR_W = $clog2(IQ_DEPTH);

    // major opcodes still supported
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode_e;

    // arithmetic ops, then compares that only drive cmp_true
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_beq,
        alu_bne,
        alu_blt,
        alu_bge,
        alu_bltu,
        alu_bgeu
    } alu_op_e;

    typedef enum logic [1:0] {
        wb_alu,
        wb_load,
        wb_link,     // pc + 4 of a jump
        wb_none
    } wb_sel_e;

endpackage

`default_nettype wire

//--- src/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu import rv32i_pkg::*; (
    input  alu_op_e         alu_op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] result,
    output logic            cmp_true
);

    logic [4:0] shamt;
    logic       lt_s, lt_u;

    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        result   = a + b;
        cmp_true = 1'b0;
        case (alu_op)
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            alu_slt:  result = {{(XLEN-1){1'b0}}, lt_s};
            alu_sltu: result = {{(XLEN-1){1'b0}}, lt_u};
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = $unsigned($signed(a) >>> shamt);
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            alu_beq:  cmp_true = (a == b);
            alu_bne:  cmp_true = (a != b);
            alu_blt:  cmp_true = lt_s;
            alu_bge:  cmp_true = !lt_s;
            alu_bltu: cmp_true = lt_u;
            alu_bgeu: cmp_true = !lt_u;
            default:  result = a + b;   // add, also load/store address
        endcase
    end

endmodule

`default_nettype wire

//--- src/regfile.sv
`timescale 1ns/10ps
`default_nettype none

module regfile import rv32i_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] waddr,
    input  logic [XLEN-1:0]       wdata,
    input  logic [REG_ADDR_W-1:0] raddr_a,
    input  logic [REG_ADDR_W-1:0] raddr_b,
    output logic [XLEN-1:0]       rdata_a,
    output logic [XLEN-1:0]       rdata_b
);

    logic [XLEN-1:0] regs [1:31];   // x0 has no storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

`default_nettype wire

//--- src/control_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module control_decoder import rv32i_pkg::*; (
    input  logic [XLEN-1:0]       instr,
    output logic [REG_ADDR_W-1:0] rs1,
    output logic [REG_ADDR_W-1:0] rs2,
    output logic [REG_ADDR_W-1:0] rd,
    output logic [XLEN-1:0]       imm,
    output rv32i_opcode_e         opcode,
    output alu_op_e               alu_op,
    output logic                  alu_src_imm,
    output logic                  alu_src_pc,
    output wb_sel_e               wb_sel,
    output logic                  is_branch,
    output logic                  is_jal,
    output logic                  is_jalr,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic                  illegal
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    alu_op_e    arith_op;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign opcode = rv32i_opcode_e'(instr[6:0]);
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    // shared by OP and OP-IMM, sub only exists as a register op
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == op_reg && funct7[5]) ? alu_sub : alu_add;
            3'b001:  arith_op = alu_sll;
            3'b010:  arith_op = alu_slt;
            3'b011:  arith_op = alu_sltu;
            3'b100:  arith_op = alu_xor;
            3'b101:  arith_op = funct7[5] ? alu_sra : alu_srl;
            3'b110:  arith_op = alu_or;
            default: arith_op = alu_and;
        endcase
    end

    always_comb begin
        imm         = '0;
        alu_op      = alu_add;
        alu_src_imm = 1'b1;
        alu_src_pc  = 1'b0;
        wb_sel      = wb_none;
        is_branch   = 1'b0;
        is_jal      = 1'b0;
        is_jalr     = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        illegal     = 1'b0;
        case (opcode)
            op_lui: begin
                imm    = {instr[31:12], 12'h000};
                wb_sel = wb_alu;
            end
            op_auipc: begin
                imm        = {instr[31:12], 12'h000};
                alu_src_pc = 1'b1;
                wb_sel     = wb_alu;
            end
            op_jal: begin
                imm    = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
                is_jal = 1'b1;
                wb_sel = wb_link;
            end
            op_jalr: begin
                imm     = {{21{instr[31]}}, instr[30:20]};
                is_jalr = 1'b1;
                wb_sel  = wb_link;
            end
            op_br: begin
                imm         = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
                is_branch   = 1'b1;
                alu_src_imm = 1'b0;     // compare rs1 with rs2
                case (funct3)
                    3'b000:  alu_op = alu_beq;
                    3'b001:  alu_op = alu_bne;
                    3'b100:  alu_op = alu_blt;
                    3'b101:  alu_op = alu_bge;
                    3'b110:  alu_op = alu_bltu;
                    3'b111:  alu_op = alu_bgeu;
                    default: illegal = 1'b1;
                endcase
            end
            op_load: begin
                imm      = {{21{instr[31]}}, instr[30:20]};
                mem_read = 1'b1;
                wb_sel   = wb_load;
                illegal  = (funct3 != 3'b010);  // word access only
            end
            op_store: begin
                imm       = {{21{instr[31]}}, instr[30:25], instr[11:7]};
                mem_write = 1'b1;
                illegal   = (funct3 != 3'b010);
            end
            op_imm: begin
                imm    = {{21{instr[31]}}, instr[30:20]};
                alu_op = arith_op;
                wb_sel = wb_alu;
            end
            op_reg: begin
                alu_src_imm = 1'b0;
                alu_op      = arith_op;
                wb_sel      = wb_alu;
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

//--- src/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_unit import rv32i_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    output logic            inst_read,
    output logic [XLEN-1:0] inst_addr,
    input  logic            inst_resp,
    input  logic [XLEN-1:0] inst_rdata,
    output logic            fq_valid,
    output logic [XLEN-1:0] fq_instr,
    output logic [XLEN-1:0] fq_pc,
    input  logic            fq_ready,
    input  logic            redirect,
    input  logic [XLEN-1:0] redirect_pc
);

    typedef enum logic [1:0] {
        fs_idle,
        fs_wait,
        fs_discard      // finishing a request that a redirect made stale
    } fetch_state_e;

    fetch_state_e    state;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] stale_addr;
    logic            req_live;

    // only start a request when the queue has room for the answer
    assign inst_read = (state == fs_idle) ? fq_ready : 1'b1;
    assign inst_addr = (state == fs_discard) ? stale_addr : pc;
    assign req_live  = inst_read && !inst_resp;  // request continues next cycle

    assign fq_valid = inst_resp && (state != fs_discard) && !redirect;
    assign fq_instr = inst_rdata;
    assign fq_pc    = pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= fs_idle;
            pc    <= RESET_PC;
        end else begin
            if (redirect)
                pc <= redirect_pc;
            else if (fq_valid && fq_ready)
                pc <= pc + XLEN'(4);

            if (state == fs_discard) begin
                if (inst_resp)
                    state <= fs_idle;
            end else if (req_live) begin
                state <= redirect ? fs_discard : fs_wait;
            end else begin
                state <= fs_idle;
            end
        end
    end

    // keep the old address on the port until the stale response arrives
    always_ff @(posedge clk) begin
        if (redirect && req_live && state != fs_discard)
            stale_addr <= pc;
    end

endmodule

`default_nettype wire

//--- src/inst_queue.sv
`timescale 1ns/10ps
`default_nettype none

module inst_queue import rv32i_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            flush,
    input  logic            in_valid,
    input  logic [XLEN-1:0] in_instr,
    input  logic [XLEN-1:0] in_pc,
    output logic            in_ready,
    output logic            out_valid,
    output logic [XLEN-1:0] out_instr,
    output logic [XLEN-1:0] out_pc,
    input  logic            out_ready
);

    logic [XLEN-1:0] instr_mem [IQ_DEPTH];
    logic [XLEN-1:0] pc_mem    [IQ_DEPTH];
    logic [IQ_PTR_W-1:0] wr_ptr, rd_ptr;
    logic [IQ_PTR_W:0]   count;
    logic push, pop;

    assign in_ready  = (count != (IQ_PTR_W+1)'(IQ_DEPTH));
    assign out_valid = (count != '0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign out_instr = instr_mem[rd_ptr];
    assign out_pc    = pc_mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin  // drops the head too
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            count <= count + (IQ_PTR_W+1)'(push) - (IQ_PTR_W+1)'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push && !flush) begin
            instr_mem[wr_ptr] <= in_instr;
            pc_mem[wr_ptr]    <= in_pc;
        end
    end

endmodule

`default_nettype wire

//--- src/execute_unit.sv
`timescale 1ns/10ps
`default_nettype none

module execute_unit import rv32i_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            iq_valid,
    input  logic [XLEN-1:0] iq_instr,
    input  logic [XLEN-1:0] iq_pc,
    output logic            iq_ready,
    output logic            data_read,
    output logic            data_write,
    output logic [XLEN-1:0] data_addr,
    output logic [XLEN-1:0] data_wdata,
    input  logic            data_resp,
    input  logic [XLEN-1:0] data_rdata,
    output logic            redirect,
    output logic [XLEN-1:0] redirect_pc
);

    logic [REG_ADDR_W-1:0] rs1, rs2, rd;
    logic [XLEN-1:0]       imm;
    rv32i_opcode_e         opcode;
    alu_op_e               alu_op;
    wb_sel_e               wb_sel;
    logic alu_src_imm, alu_src_pc;
    logic is_branch, is_jal, is_jalr, mem_read, mem_write, illegal;
    logic [XLEN-1:0] rs1_val, rs2_val, alu_a, alu_b, alu_result;
    logic [XLEN-1:0] target_sum, wb_data;
    logic            cmp_true, active, mem_op, retire, wb_en;

    control_decoder control_decoder_i (
        .instr(iq_instr), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
        .opcode(opcode), .alu_op(alu_op),
        .alu_src_imm(alu_src_imm), .alu_src_pc(alu_src_pc), .wb_sel(wb_sel),
        .is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr),
        .mem_read(mem_read), .mem_write(mem_write), .illegal(illegal)
    );

    regfile regfile_i (
        .clk(clk), .rst_n(rst_n),
        .we(wb_en), .waddr(rd), .wdata(wb_data),
        .raddr_a(rs1), .raddr_b(rs2),
        .rdata_a(rs1_val), .rdata_b(rs2_val)
    );

    alu alu_i (
        .alu_op(alu_op), .a(alu_a), .b(alu_b),
        .result(alu_result), .cmp_true(cmp_true)
    );

    // lui reads no register, its rs1 bits belong to the immediate
    assign alu_a = (opcode == op_lui) ? '0 : (alu_src_pc ? iq_pc : rs1_val);
    assign alu_b = alu_src_imm ? imm : rs2_val;

    // illegal words retire as no-ops
    assign active = iq_valid && !illegal;
    assign mem_op = active && (mem_read || mem_write);

    // head stays put until data_resp, so the port holds by itself
    assign data_read  = mem_op && mem_read;
    assign data_write = mem_op && mem_write;
    assign data_addr  = alu_result;
    assign data_wdata = rs2_val;

    assign iq_ready = !mem_op || data_resp;
    assign retire   = iq_valid && iq_ready;

    // separate target adder, jalr drops bit 0
    assign target_sum  = (is_jalr ? rs1_val : iq_pc) + imm;
    assign redirect_pc = {target_sum[XLEN-1:1], target_sum[0] & !is_jalr};
    assign redirect    = retire && active && (is_jal || is_jalr || (is_branch && cmp_true));

    assign wb_en = retire && active && (wb_sel != wb_none);

    always_comb begin
        case (wb_sel)
            wb_load: wb_data = data_rdata;
            wb_link: wb_data = iq_pc + XLEN'(4);
            default: wb_data = alu_result;
        endcase
    end

endmodule

`default_nettype wire

//--- src/rv32i_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv32i_core import rv32i_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    output logic            inst_read,
    output logic [XLEN-1:0] inst_addr,
    input  logic            inst_resp,
    input  logic [XLEN-1:0] inst_rdata,
    output logic            data_read,
    output logic            data_write,
    output logic [XLEN-1:0] data_addr,
    output logic [XLEN-1:0] data_wdata,
    input  logic            data_resp,
    input  logic [XLEN-1:0] data_rdata
);

    logic            fq_valid, fq_ready;
    logic [XLEN-1:0] fq_instr, fq_pc;
    logic            iq_valid, iq_ready;
    logic [XLEN-1:0] iq_instr, iq_pc;
    logic            redirect;
    logic [XLEN-1:0] redirect_pc;

    fetch_unit fetch_unit_i (
        .clk(clk), .rst_n(rst_n),
        .inst_read(inst_read), .inst_addr(inst_addr),
        .inst_resp(inst_resp), .inst_rdata(inst_rdata),
        .fq_valid(fq_valid), .fq_instr(fq_instr), .fq_pc(fq_pc), .fq_ready(fq_ready),
        .redirect(redirect), .redirect_pc(redirect_pc)
    );

    inst_queue inst_queue_i (
        .clk(clk), .rst_n(rst_n), .flush(redirect),
        .in_valid(fq_valid), .in_instr(fq_instr), .in_pc(fq_pc), .in_ready(fq_ready),
        .out_valid(iq_valid), .out_instr(iq_instr), .out_pc(iq_pc), .out_ready(iq_ready)
    );

    execute_unit execute_unit_i (
        .clk(clk), .rst_n(rst_n),
        .iq_valid(iq_valid), .iq_instr(iq_instr), .iq_pc(iq_pc), .iq_ready(iq_ready),
        .data_read(data_read), .data_write(data_write),
        .data_addr(data_addr), .data_wdata(data_wdata),
        .data_resp(data_resp), .data_rdata(data_rdata),
        .redirect(redirect), .redirect_pc(redirect_pc)
    );

endmodule

`default_nettype wire

//--- verification/tb_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mem_model import rv32i_pkg::*; #(
    parameter int SEED = 32'h94fe
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            inst_read,
    input  logic [XLEN-1:0] inst_addr,
    output logic            inst_resp,
    output logic [XLEN-1:0] inst_rdata,
    input  logic            data_read,
    input  logic            data_write,
    input  logic [XLEN-1:0] data_addr,
    input  logic [XLEN-1:0] data_wdata,
    output logic            data_resp,
    output logic [XLEN-1:0] data_rdata
);

    logic [XLEN-1:0] mem [0:255];   // word addressed, 1 KiB
    integer          seed = SEED;
    logic            inst_busy, data_busy;
    logic [1:0]      inst_cnt, data_cnt;

    // one block for both ports keeps the random draw order fixed
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inst_resp  <= 1'b0;
            inst_busy  <= 1'b0;
            inst_cnt   <= 2'd0;
            inst_rdata <= '0;
            data_resp  <= 1'b0;
            data_busy  <= 1'b0;
            data_cnt   <= 2'd0;
            data_rdata <= '0;
        end else begin
            inst_resp <= 1'b0;
            data_resp <= 1'b0;
            if (inst_read && !inst_resp) begin
                if (!inst_busy) begin
                    inst_busy <= 1'b1;
                    inst_cnt  <= 2'($unsigned($random(seed)) % 32'd4);
                end else if (inst_cnt == 2'd0) begin
                    inst_resp  <= 1'b1;
                    inst_rdata <= mem[inst_addr[9:2]];
                    inst_busy  <= 1'b0;
                end else begin
                    inst_cnt <= inst_cnt - 2'd1;
                end
            end
            if ((data_read || data_write) && !data_resp) begin
                if (!data_busy) begin
                    data_busy <= 1'b1;
                    data_cnt  <= 2'($unsigned($random(seed)) % 32'd4);
                end else if (data_cnt == 2'd0) begin
                    data_resp  <= 1'b1;
                    data_rdata <= mem[data_addr[9:2]];
                    data_busy  <= 1'b0;
                    if (data_write)
                        mem[data_addr[9:2]] <= data_wdata;
                end else begin
                    data_cnt <= data_cnt - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_rv32i_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv32i_core import rv32i_pkg::*; #(
    parameter int SEED    = 32'h94fe,
    parameter int TIMEOUT = 4000
);

    localparam logic [XLEN-1:0] MARKER_ADDR = 32'h0000_03FC;
    localparam int              NUM_TARGETS = 9;
    // taken branch and jump targets in program order
    localparam logic [XLEN-1:0] TARGETS [NUM_TARGETS] = '{
        32'd88, 32'd96, 32'd104, 32'd112, 32'd120, 32'd136, 32'd148, 32'd164, 32'd268
    };

    logic            clk, rst_n;
    logic            inst_read, inst_resp, data_read, data_write, data_resp;
    logic [XLEN-1:0] inst_addr, inst_rdata, data_addr, data_wdata, data_rdata;
    logic [XLEN-1:0] exp_addr [$];
    logic [XLEN-1:0] exp_data [$];
    int              pc_idx, st_idx, tgt_idx;
    logic            req_start, target_due;

    rv32i_core rv32i_core_i (
        .clk(clk), .rst_n(rst_n),
        .inst_read(inst_read), .inst_addr(inst_addr),
        .inst_resp(inst_resp), .inst_rdata(inst_rdata),
        .data_read(data_read), .data_write(data_write),
        .data_addr(data_addr), .data_wdata(data_wdata),
        .data_resp(data_resp), .data_rdata(data_rdata)
    );

    tb_mem_model #(.SEED(SEED)) mem_i (
        .clk(clk), .rst_n(rst_n),
        .inst_read(inst_read), .inst_addr(inst_addr),
        .inst_resp(inst_resp), .inst_rdata(inst_rdata),
        .data_read(data_read), .data_write(data_write),
        .data_addr(data_addr), .data_wdata(data_wdata),
        .data_resp(data_resp), .data_rdata(data_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic report_error(input string msg);
        abort_run($sformatf("CHECK FAILED at %0t: %s", $time, msg));
    endtask

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'(op_reg)};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'(op_store)};
    endfunction

    function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'(op_br)};
    endfunction

    function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_word(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'(op_jal)};
    endfunction

    task automatic put(input logic [31:0] word);
        mem_i.mem[8'(pc_idx)] = word;
        pc_idx++;
    endtask

    // sw rs2, off(x10) with x10 = 0x200
    task automatic put_store(input logic [11:0] off, input logic [4:0] rs2,
                             input logic [31:0] data);
        put(s_word(off, rs2, 5'd10));
        exp_addr.push_back(32'h200 + 32'(off));
        exp_data.push_back(data);
    endtask

    task automatic load_program();
        logic [31:0] marker;
        marker = s_word(12'h1FC, 5'd1, 5'd10);
        for (int i = 0; i < 256; i++)
            mem_i.mem[8'(i)] = 32'hC0DE_0000 ^ (32'(i) * 32'h0001_0001);
        mem_i.mem[8'hC0] = 32'h0000_0041;              // load source at 0x300
        pc_idx = 0;
        put(i_word(12'h200, 5'd0, 3'b000, 5'd10, op_imm));
        put(i_word(12'hFFB, 5'd0, 3'b000, 5'd1, op_imm)); // x1 = -5
        put(i_word(12'd3, 5'd0, 3'b000, 5'd2, op_imm));
        put(r_word(7'h20, 5'd1, 5'd2, 3'b000, 5'd3));     // sub
        put_store(12'd0, 5'd3, 32'd8);
        put(r_word(7'h20, 5'd2, 5'd1, 3'b101, 5'd4));     // sra
        put_store(12'd4, 5'd4, 32'hFFFF_FFFF);
        put(r_word(7'h00, 5'd1, 5'd2, 3'b011, 5'd5));     // sltu
        put_store(12'd8, 5'd5, 32'd1);
        put(i_word(12'h0F0, 5'd1, 3'b100, 5'd6, op_imm));
        put_store(12'd12, 5'd6, 32'hFFFF_FF0B);
        put(i_word(12'd28, 5'd1, 3'b101, 5'd7, op_imm));  // srli
        put_store(12'd16, 5'd7, 32'h0000_000F);
        put(u_word(20'h12345, 5'd8, op_lui));
        put_store(12'd20, 5'd8, 32'h1234_5000);
        put(u_word(20'h00001, 5'd9, op_auipc));          // pc 0x3c
        put_store(12'd24, 5'd9, 32'h0000_103C);
        put(i_word(12'h100, 5'd10, 3'b010, 5'd11, op_load));
        put(i_word(12'd1, 5'd11, 3'b000, 5'd11, op_imm));
        put_store(12'd28, 5'd11, 32'h0000_0042);
        put(b_word(13'd8, 5'd2, 5'd1, 3'b100));          // blt taken
        put(marker);
        put(b_word(13'd8, 5'd2, 5'd1, 3'b111));          // bgeu taken
        put(marker);
        put(b_word(13'd8, 5'd2, 5'd2, 3'b000));          // beq taken
        put(marker);
        put(b_word(13'd8, 5'd1, 5'd2, 3'b101));          // bge taken
        put(marker);
        put(b_word(13'd8, 5'd1, 5'd2, 3'b110));          // bltu taken
        put(marker);
        put(b_word(13'd8, 5'd1, 5'd1, 3'b001));          // bne falls through
        put_store(12'd32, 5'd2, 32'd3);
        put(j_word(21'd8, 5'd12));                       // pc 0x80
        put(marker);
        put(i_word(12'd147, 5'd0, 3'b000, 5'd13, op_imm));
        put(i_word(12'd2, 5'd13, 3'b000, 5'd14, op_jalr)); // odd sum lands on 0x94
        put(marker);
        put_store(12'd36, 5'd12, 32'h0000_0084);
        put_store(12'd40, 5'd14, 32'h0000_0090);
        put(b_word(13'd8, 5'd2, 5'd1, 3'b001));          // bne taken, pc 0x9c
        put(marker);
        put(r_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd15));    // add
        put_store(12'd44, 5'd15, 32'hFFFF_FFFE);
        put(r_word(7'h00, 5'd2, 5'd1, 3'b001, 5'd15));    // sll
        put_store(12'd48, 5'd15, 32'hFFFF_FFD8);
        put(r_word(7'h00, 5'd2, 5'd1, 3'b010, 5'd15));    // slt
        put_store(12'd52, 5'd15, 32'd1);
        put(r_word(7'h00, 5'd7, 5'd6, 3'b100, 5'd15));    // xor
        put_store(12'd56, 5'd15, 32'hFFFF_FF04);
        put(r_word(7'h00, 5'd2, 5'd1, 3'b101, 5'd15));    // srl
        put_store(12'd60, 5'd15, 32'h1FFF_FFFF);
        put(r_word(7'h00, 5'd7, 5'd6, 3'b110, 5'd15));    // or
        put_store(12'd64, 5'd15, 32'hFFFF_FF0F);
        put(r_word(7'h00, 5'd7, 5'd6, 3'b111, 5'd15));    // and
        put_store(12'd68, 5'd15, 32'h0000_000B);
        put(i_word(12'hFFF, 5'd2, 3'b010, 5'd15, op_imm)); // slti 3 < -1
        put_store(12'd72, 5'd15, 32'd0);
        put(i_word(12'hFFF, 5'd2, 3'b011, 5'd15, op_imm)); // sltiu
        put_store(12'd76, 5'd15, 32'd1);
        put(i_word(12'h013, 5'd7, 3'b110, 5'd15, op_imm)); // ori
        put_store(12'd80, 5'd15, 32'h0000_001F);
        put(i_word(12'h0F0, 5'd1, 3'b111, 5'd15, op_imm)); // andi
        put_store(12'd84, 5'd15, 32'h0000_00F0);
        put(i_word(12'h004, 5'd1, 3'b001, 5'd15, op_imm)); // slli
        put_store(12'd88, 5'd15, 32'hFFFF_FFB0);
        put(i_word(12'h401, 5'd1, 3'b101, 5'd15, op_imm)); // srai
        put_store(12'd92, 5'd15, 32'hFFFF_FFFD);
        put(j_word(21'd0, 5'd0));                        // spin here, pc 0x10c
    endtask

    initial begin
        int cyc;
        rst_n = 1'b0;
        load_program();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (inst_read && inst_addr == RESET_PC && !data_read && !data_write)
            else report_error("port state wrong in first cycle after reset");
        for (cyc = 0; cyc < TIMEOUT; cyc++) begin
            if (st_idx >= exp_addr.size() && tgt_idx >= NUM_TARGETS)
                break;
            @(posedge clk);
        end
        if (st_idx < exp_addr.size() || tgt_idx < NUM_TARGETS) begin
            abort_run("timed out before the final store and jump were seen");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

    // every completed store against the table
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st_idx <= 0;
        end else if (data_write && data_resp) begin
            assert (data_addr != MARKER_ADDR)
                else report_error("store after a taken branch or jump executed");
            assert (st_idx < exp_addr.size() && data_addr == exp_addr[st_idx]
                    && data_wdata == exp_data[st_idx])
                else report_error($sformatf("store %0d wrote %h to %h", st_idx,
                                            data_wdata, data_addr));
            st_idx <= st_idx + 1;
        end
    end

    // first new fetch after a redirect must go to the target
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_start  <= 1'b1;
            target_due <= 1'b0;
            tgt_idx    <= 0;
        end else begin
            if (inst_read)
                req_start <= inst_resp;
            if (inst_read && req_start && target_due) begin
                assert (inst_addr == TARGETS[4'(tgt_idx)])
                    else report_error($sformatf("fetch after redirect at %h", inst_addr));
                tgt_idx    <= tgt_idx + 1;
                target_due <= 1'b0;
            end
            if (rv32i_core_i.redirect && tgt_idx < NUM_TARGETS)
                target_due <= 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(data_read && data_write))
        else report_error("data_read and data_write both high");

    assert property (@(posedge clk) disable iff (!rst_n)
        inst_read && !inst_resp |=> inst_read && $stable(inst_addr))
        else report_error("inst_addr moved while waiting for inst_resp");

    assert property (@(posedge clk) disable iff (!rst_n)
        (data_read || data_write) && !data_resp |=>
            $stable(data_addr) && $stable(data_read) && $stable(data_write))
        else report_error("data port moved while waiting for data_resp");

endmodule

`default_nettype wire

//--- filelist.f
src/rv32i_pkg.sv
src/alu.sv
src/regfile.sv
src/control_decoder.sv
src/fetch_unit.sv
src/inst_queue.sv
src/execute_unit.sv
src/rv32i_core.sv
verification/tb_mem_model.sv
verification/tb_rv32i_core.sv

//--- Makefile
TOP       ?= tb_rv32i_core
SEED      ?= 38142
TIMEOUT   ?= 4000
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VERILATOR ?= verilator

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   show this list"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "variables: TOP SEED TIMEOUT BUILD_DIR LOG VERILATOR"

test:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) -Mdir $(BUILD_DIR) \
		-GSEED=$(SEED) -GTIMEOUT=$(TIMEOUT) -f filelist.f
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR)
